// ==== hdl/argmax.sv ====
`timescale 1ns/10ps

module argmax #(
    parameter int SIZE       = 7,
    parameter int INDEX_BITS = 3,
    parameter int BITS       = 7
) (
    input  logic [SIZE*BITS-1:0]  inx,      // slice 0 holds entry 0
    output logic [INDEX_BITS-1:0] outimax
);

    logic [BITS-1:0]       best_val;
    logic [INDEX_BITS-1:0] best_idx;

    // only a strictly larger score replaces the current best
    // so that ties resolve to the lowest index
    always_comb begin
        best_val = inx[BITS-1:0];
        best_idx = '0;
        for (int i = 1; i < SIZE; i++) begin
            if (inx[i*BITS +: BITS] > best_val) begin
                best_val = inx[i*BITS +: BITS];
                best_idx = INDEX_BITS'(i);
            end
        end
    end

    assign outimax = best_idx;

endmodule

// ==== hdl/class_tally.sv ====
`timescale 1ns/10ps

module class_tally #(
    parameter int COUNT_BITS = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hit,
    input  winewhite_pkg::class_t  hit_class,
    input  logic                   clear,
    input  logic                   rd,
    input  winewhite_pkg::class_t  sel,
    output logic                   rd_valid,
    output logic [COUNT_BITS-1:0]  count
);

    logic [COUNT_BITS-1:0] counters [winewhite_pkg::CLASS_CNT];
    logic                  hit_ok;

    // hits on the unused class 7 are dropped
    assign hit_ok = hit && (hit_class < winewhite_pkg::CLASS_CNT);

    always_ff @(posedge clk) begin
        if (rst || clear) begin    // clear wins over a same-edge hit
            for (int c = 0; c < winewhite_pkg::CLASS_CNT; c++)
                counters[c] <= '0;
        end else if (hit_ok && !(&counters[hit_class])) begin
            counters[hit_class] <= counters[hit_class] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd;
    end

    // the read samples the counts before any update at the same edge
    always_ff @(posedge clk) begin
        if (rd) begin
            if (sel < winewhite_pkg::CLASS_CNT)
                count <= counters[sel];
            else
                count <= '0;
        end
    end

endmodule

// ==== hdl/winewhite_classifier.sv ====
`timescale 1ns/10ps

module winewhite_classifier #(
    parameter int TALLY_BITS = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  winewhite_pkg::features_t  features,
    output logic                      out_valid,
    output winewhite_pkg::class_t     prediction,
    input  logic                      tally_clear,
    input  logic                      tally_rd,
    input  winewhite_pkg::class_t     tally_sel,
    output logic                      tally_valid,
    output logic [TALLY_BITS-1:0]     tally_count
);

    winewhite_pkg::features_t sample_q;
    logic                     stage1_valid;
    winewhite_pkg::class_t    net_class;

    // the valid bit runs two stages to match the sample and prediction registers
    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            stage1_valid <= in_valid;
            out_valid    <= stage1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            sample_q <= features;
        if (stage1_valid)
            prediction <= net_class;    // network settles within one cycle
    end

    winewhite_tp u_net (
        .features  (sample_q),
        .prediction(net_class)
    );

    // counts each prediction on the edge where out_valid is high
    class_tally #(
        .COUNT_BITS(TALLY_BITS)
    ) u_tally (
        .clk      (clk),
        .rst      (rst),
        .hit      (out_valid),
        .hit_class(prediction),
        .clear    (tally_clear),
        .rd       (tally_rd),
        .sel      (tally_sel),
        .rd_valid (tally_valid),
        .count    (tally_count)
    );

endmodule

// ==== hdl/winewhite_pkg.sv ====
package winewhite_pkg;

    // network sizes are fixed by the trained weights below
    localparam int FEAT_CNT   = 11;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 7;
    localparam int SUM_BITS   = 6;    // popcount of up to 40 hidden bits

    typedef logic [FEAT_BITS-1:0]          feature_t;
    typedef logic [FEAT_CNT*FEAT_BITS-1:0] features_t;  // feature 0 in the top nibble
    typedef logic [2:0]                    class_t;
    typedef logic [SUM_BITS:0]             score_t;     // 2 * popcount + bias

    // kind of each hidden unit after training pruned some to constants
    typedef enum logic [1:0] {
        HID_CMP,     // positive feature sum >= negative feature sum
        HID_ONE,
        HID_ZERO
    } hidden_op_t;

    localparam hidden_op_t HIDDEN_OP [HIDDEN_CNT] = '{
        HID_CMP,  HID_ONE,  HID_CMP,  HID_CMP,
        HID_CMP,  HID_CMP,  HID_CMP,  HID_CMP,
        HID_CMP,  HID_CMP,  HID_CMP,  HID_CMP,
        HID_CMP,  HID_CMP,  HID_CMP,  HID_CMP,
        HID_ONE,  HID_CMP,  HID_CMP,  HID_CMP,
        HID_CMP,  HID_CMP,  HID_CMP,  HID_ONE,
        HID_CMP,  HID_CMP,  HID_ZERO, HID_CMP,
        HID_ZERO, HID_CMP,  HID_CMP,  HID_CMP,
        HID_ONE,  HID_ONE,  HID_CMP,  HID_CMP,
        HID_CMP,  HID_CMP,  HID_CMP,  HID_CMP
    };

    // bit f set means feature f is added on that side of the unit
    localparam logic [FEAT_CNT-1:0] HID_POS_MASK [HIDDEN_CNT] = '{
        11'h090, 11'h000, 11'h704, 11'h021,
        11'h628, 11'h040, 11'h0de, 11'h003,
        11'h046, 11'h4d0, 11'h068, 11'h156,
        11'h0a6, 11'h114, 11'h20e, 11'h040,
        11'h000, 11'h021, 11'h0ce, 11'h042,
        11'h423, 11'h183, 11'h507, 11'h000,
        11'h047, 11'h408, 11'h000, 11'h258,
        11'h000, 11'h421, 11'h2b8, 11'h4a0,
        11'h000, 11'h000, 11'h038, 11'h347,
        11'h202, 11'h042, 11'h006, 11'h460
    };

    localparam logic [FEAT_CNT-1:0] HID_NEG_MASK [HIDDEN_CNT] = '{
        11'h303, 11'h000, 11'h0f0, 11'h0d2,
        11'h013, 11'h08c, 11'h200, 11'h4f0,
        11'h321, 11'h109, 11'h080, 11'h620,
        11'h600, 11'h420, 11'h4d0, 11'h188,
        11'h000, 11'h192, 11'h500, 11'h23c,
        11'h0d0, 11'h608, 11'h068, 11'h000,
        11'h4a8, 11'h092, 11'h000, 11'h004,
        11'h000, 11'h38e, 11'h002, 11'h003,
        11'h000, 11'h000, 11'h046, 11'h098,
        11'h0e4, 11'h238, 11'h400, 11'h191
    };

    // hidden bits a class counts as true
    localparam logic [HIDDEN_CNT-1:0] CLS_POS_MASK [CLASS_CNT] = '{
        40'h00_1014_8890,
        40'h60_1158_0880,
        40'h30_0114_0000,
        40'h20_8181_8002,
        40'h00_1040_0000,
        40'h00_8000_0000,
        40'h20_0114_2030
    };

    // hidden bits a class counts inverted
    localparam logic [HIDDEN_CNT-1:0] CLS_NEG_MASK [CLASS_CNT] = '{
        40'h40_0081_0642,
        40'h04_c081_0400,
        40'h02_0200_0200,
        40'h02_0000_0000,
        40'h02_0021_1100,
        40'h02_0081_2800,
        40'h4f_4883_1046
    };

    localparam score_t CLS_BIAS [CLASS_CNT] = '{
        7'd7, 7'd6, 7'd13, 7'd13, 7'd14, 7'd15, 7'd0
    };

endpackage

// ==== hdl/winewhite_tp.sv ====
`timescale 1ns/10ps

module winewhite_tp (
    input  winewhite_pkg::features_t features,
    output winewhite_pkg::class_t    prediction
);

    // a unit sums at most all eleven features
    localparam int ACC_BITS   = $clog2(winewhite_pkg::FEAT_CNT + 1) + winewhite_pkg::FEAT_BITS;
    localparam int SCORE_BITS = $bits(winewhite_pkg::score_t);

    winewhite_pkg::feature_t                 feature_array [winewhite_pkg::FEAT_CNT];
    logic [winewhite_pkg::HIDDEN_CNT-1:0]    hidden;
    logic [winewhite_pkg::CLASS_CNT*SCORE_BITS-1:0] score_vec;

    for (genvar i = 0; i < winewhite_pkg::FEAT_CNT; i++) begin : g_unpack
        assign feature_array[winewhite_pkg::FEAT_CNT-1-i] =
            features[i*winewhite_pkg::FEAT_BITS +: winewhite_pkg::FEAT_BITS];
    end

    for (genvar h = 0; h < winewhite_pkg::HIDDEN_CNT; h++) begin : g_hidden
        logic [ACC_BITS-1:0] pos_sum;
        logic [ACC_BITS-1:0] neg_sum;
        logic                unit;

        always_comb begin
            pos_sum = '0;
            neg_sum = '0;
            for (int f = 0; f < winewhite_pkg::FEAT_CNT; f++) begin
                if (winewhite_pkg::HID_POS_MASK[h][f])
                    pos_sum = pos_sum + ACC_BITS'(feature_array[f]);
                if (winewhite_pkg::HID_NEG_MASK[h][f])
                    neg_sum = neg_sum + ACC_BITS'(feature_array[f]);
            end
        end

        always_comb begin
            case (winewhite_pkg::HIDDEN_OP[h])
                winewhite_pkg::HID_ONE:  unit = 1'b1;
                winewhite_pkg::HID_ZERO: unit = 1'b0;
                default:                 unit = (pos_sum >= neg_sum);
            endcase
        end

        assign hidden[h] = unit;
    end

    for (genvar c = 0; c < winewhite_pkg::CLASS_CNT; c++) begin : g_class
        logic [winewhite_pkg::HIDDEN_CNT-1:0] picked;
        logic [winewhite_pkg::SUM_BITS-1:0]   popcount;
        winewhite_pkg::score_t                score;

        // the two masks never overlap, so one OR merges true and inverted taps
        assign picked = (hidden & winewhite_pkg::CLS_POS_MASK[c])
                      | (~hidden & winewhite_pkg::CLS_NEG_MASK[c]);

        always_comb begin
            popcount = '0;
            for (int j = 0; j < winewhite_pkg::HIDDEN_CNT; j++)
                popcount = popcount + winewhite_pkg::SUM_BITS'(picked[j]);
        end

        assign score = {popcount, 1'b0} + winewhite_pkg::CLS_BIAS[c];
        assign score_vec[c*SCORE_BITS +: SCORE_BITS] = score;
    end

    argmax #(
        .SIZE      (winewhite_pkg::CLASS_CNT),
        .INDEX_BITS($bits(winewhite_pkg::class_t)),
        .BITS      (SCORE_BITS)
    ) result (
        .inx    (score_vec),
        .outimax(prediction)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the winewhite testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module winewhite_tb \
    -f winewhite.f \
    -o winewhite_sim

output=$(./obj_dir/winewhite_sim 2>&1 || true)
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== testbench/winewhite_assert.sv ====
`timescale 1ns/10ps

module winewhite_assert (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_valid,
    input logic tally_rd,
    input logic tally_valid
);

    // once two clean edges have passed, out_valid is in_valid two edges ago
    property out_follows_in;
        @(posedge clk) disable iff (rst)
            (!$past(rst) && !$past(rst, 2)) |-> (out_valid == $past(in_valid, 2));
    endproperty

    property quiet_in_reset;
        @(posedge clk) $past(rst) |-> (!out_valid && !tally_valid);
    endproperty

    property read_answers_next_cycle;
        @(posedge clk) disable iff (rst)
            !$past(rst) |-> (tally_valid == $past(tally_rd));
    endproperty

    a_out_follows_in: assert property (out_follows_in)
        else $error("out_valid is not in_valid delayed by two cycles");

    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("out_valid or tally_valid high while in reset");

    a_read_answers: assert property (read_answers_next_cycle)
        else $error("tally_valid does not follow tally_rd by one cycle");

endmodule

bind winewhite_classifier winewhite_assert u_assert (
    .clk(clk), .rst(rst), .in_valid(in_valid), .out_valid(out_valid),
    .tally_rd(tally_rd), .tally_valid(tally_valid)
);

// ==== testbench/winewhite_tb.sv ====
`timescale 1ns/10ps

module winewhite_tb;

    localparam int TALLY_BITS = 10;
    localparam int TIMEOUT    = 50;    // cycles allowed for any single wait

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    winewhite_pkg::features_t  features;
    logic                      out_valid;
    winewhite_pkg::class_t     prediction;
    logic                      tally_clear;
    logic                      tally_rd;
    winewhite_pkg::class_t     tally_sel;
    logic                      tally_valid;
    logic [TALLY_BITS-1:0]     tally_count;

    winewhite_pkg::class_t     expected_q [$];
    logic [TALLY_BITS-1:0]     model_count [winewhite_pkg::CLASS_CNT];
    winewhite_pkg::class_t     mon_class;
    int errors;
    int errors_before;
    int samples;    // samples sent since the last tally clear
    int tests_run;
    int tests_failed;

    winewhite_classifier #(.TALLY_BITS(TALLY_BITS)) u_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .features(features),
        .out_valid(out_valid), .prediction(prediction),
        .tally_clear(tally_clear), .tally_rd(tally_rd), .tally_sel(tally_sel),
        .tally_valid(tally_valid), .tally_count(tally_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // golden model built straight from the weight tables
    function automatic winewhite_pkg::class_t model_predict(input winewhite_pkg::features_t s);
        int feat [winewhite_pkg::FEAT_CNT];
        bit hid [winewhite_pkg::HIDDEN_CNT];
        int pos;
        int neg;
        int cnt;
        int score;
        int best;
        winewhite_pkg::class_t idx;
        for (int f = 0; f < winewhite_pkg::FEAT_CNT; f++)
            feat[f] = s[(winewhite_pkg::FEAT_CNT-1-f)*winewhite_pkg::FEAT_BITS +: 4];
        for (int h = 0; h < winewhite_pkg::HIDDEN_CNT; h++) begin
            pos = 0;
            neg = 0;
            for (int f = 0; f < winewhite_pkg::FEAT_CNT; f++) begin
                if (winewhite_pkg::HID_POS_MASK[h][f]) pos += feat[f];
                if (winewhite_pkg::HID_NEG_MASK[h][f]) neg += feat[f];
            end
            case (winewhite_pkg::HIDDEN_OP[h])
                winewhite_pkg::HID_ONE:  hid[h] = 1'b1;
                winewhite_pkg::HID_ZERO: hid[h] = 1'b0;
                default:                 hid[h] = (pos >= neg);
            endcase
        end
        best = -1;
        idx  = '0;
        for (int c = 0; c < winewhite_pkg::CLASS_CNT; c++) begin
            cnt = 0;
            for (int h = 0; h < winewhite_pkg::HIDDEN_CNT; h++) begin
                if (winewhite_pkg::CLS_POS_MASK[c][h] && hid[h]) cnt++;
                if (winewhite_pkg::CLS_NEG_MASK[c][h] && !hid[h]) cnt++;
            end
            score = 2 * cnt + int'(winewhite_pkg::CLS_BIAS[c]);
            if (score > best) begin    // strict compare keeps the lowest index on ties
                best = score;
                idx  = winewhite_pkg::class_t'(c);
            end
        end
        return idx;
    endfunction

    function automatic winewhite_pkg::features_t random_sample();
        return winewhite_pkg::features_t'({$urandom(), $urandom()});
    endfunction

    task automatic check_class(input winewhite_pkg::class_t got, input winewhite_pkg::class_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: prediction %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_count(input logic [TALLY_BITS-1:0] got, input logic [TALLY_BITS-1:0] exp,
                               input winewhite_pkg::class_t sel);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: tally of class %0d is %0d, expected %0d",
                     $time, sel, got, exp);
        end
    endtask

    // every out_valid must match the oldest sample still in flight
    always @(negedge clk) begin
        if (out_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: out_valid came with no sample in flight", $time);
            end else begin
                mon_class = expected_q.pop_front();
                check_class(prediction, mon_class);
                if (model_count[mon_class] != '1) model_count[mon_class]++;
            end
        end
    end

    task automatic send_sample(input winewhite_pkg::features_t s);
        in_valid = 1'b1;
        features = s;
        expected_q.push_back(model_predict(s));
        samples++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic directed_sample(input winewhite_pkg::features_t s);
        int waited;
        send_sample(s);
        waited = 1;
        while (!out_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited != 2) begin
            errors++;
            $display("ERROR at %0t: out_valid came %0d cycles after in_valid instead of 2",
                     $time, waited);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d predictions never came out", $time, expected_q.size());
            expected_q.delete();
        end
        repeat (2) @(negedge clk);    // let the last increment reach the tally
    endtask

    task automatic read_tally(input winewhite_pkg::class_t sel, output logic [TALLY_BITS-1:0] val);
        int waited;
        tally_rd  = 1'b1;
        tally_sel = sel;
        @(negedge clk);
        tally_rd = 1'b0;
        waited   = 0;
        while (!tally_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!tally_valid) begin
            errors++;
            $display("ERROR at %0t: no tally_valid after reading class %0d", $time, sel);
        end
        val = tally_count;
    endtask

    task automatic check_tally_all();
        logic [TALLY_BITS-1:0] val;
        int sum;
        sum = 0;
        for (int c = 0; c < winewhite_pkg::CLASS_CNT; c++) begin
            read_tally(winewhite_pkg::class_t'(c), val);
            check_count(val, model_count[c], winewhite_pkg::class_t'(c));
            sum += int'(val);
        end
        if (sum != samples) begin
            errors++;
            $display("MISMATCH at %0t: tally sum %0d, expected %0d samples", $time, sum, samples);
        end
    endtask

    task automatic clear_tally();
        tally_clear = 1'b1;
        @(negedge clk);
        tally_clear = 1'b0;
        foreach (model_count[c]) model_count[c] = '0;
        samples = 0;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-12s pass", name);
        end else begin
            tests_failed++;
            $display("test %-12s fail, %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        winewhite_pkg::features_t s;
        void'($urandom(32'h1e42_17fa));
        rst         = 1'b1;
        in_valid    = 1'b0;
        features    = '0;
        tally_clear = 1'b0;
        tally_rd    = 1'b0;
        tally_sel   = '0;
        errors = 0;
        errors_before = 0;
        samples = 0;
        tests_run = 0;
        tests_failed = 0;
        foreach (model_count[c]) model_count[c] = '0;

        for (int i = 0; i < 10; i++) begin
            in_valid = (i >= 2 && i < 5);    // strobes in reset must not come out
            tally_rd = (i >= 4 && i < 7);
            features = random_sample();
            @(negedge clk);
            if (out_valid !== 1'b0 || tally_valid !== 1'b0) begin
                errors++;
                $display("ERROR at %0t: out_valid or tally_valid high in reset", $time);
            end
        end
        rst      = 1'b0;
        in_valid = 1'b0;
        tally_rd = 1'b0;
        check_tally_all();
        report_test("reset");

        directed_sample('0);
        directed_sample('1);
        directed_sample({{5{8'hF0}}, 4'hF});
        directed_sample({{5{8'h0F}}, 4'h0});
        for (int f = 0; f < winewhite_pkg::FEAT_CNT; f++) begin
            s = '0;
            s[(winewhite_pkg::FEAT_CNT-1-f)*winewhite_pkg::FEAT_BITS +: 4] = 4'hF;
            directed_sample(s);
        end
        drain();
        report_test("directed");

        for (int i = 0; i < 1000; i++)
            send_sample(random_sample());
        drain();
        report_test("back_to_back");

        check_tally_all();
        report_test("tally");

        clear_tally();
        check_tally_all();
        report_test("clear");

        for (int i = 0; i < 200; i++) begin
            repeat ($urandom_range(0, 4)) @(negedge clk);
            send_sample(random_sample());
        end
        drain();
        check_tally_all();    // only the samples since the clear
        report_test("gaps");

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== winewhite.f ====
hdl/winewhite_pkg.sv
hdl/argmax.sv
hdl/winewhite_tp.sv
hdl/class_tally.sv
hdl/winewhite_classifier.sv
testbench/winewhite_assert.sv
testbench/winewhite_tb.sv
